// ==== rib_soc.f ====
src/rib_pkg.sv
src/periph_pkg.sv
src/rib_arbiter.sv
src/data_ram.sv
src/timer_unit.sv
src/gpio_port.sv
src/rib_soc_top.sv
tests/tb_rib_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the rib_soc testbench with Verilator, run it to a log file and
# decide pass or fail from the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f rib_soc.f --top-module tb_rib_soc \
    -Mdir "$BUILD_DIR" -o tb_rib_soc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_rib_soc" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1

// ==== src/data_ram.sv ====
/*
 * Word RAM slave on the rib bus.
 * Combinational read of the addressed word, write at the rising edge
 * when selected with write enable. Offset wraps modulo the depth.
 */

`timescale 1ns/1ps

module data_ram #(
    parameter int unsigned RAM_DEPTH_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  rib_pkg::slave_req_t req_i,
    output logic [31:0]         rdata_o
);

    localparam int unsigned AW = (RAM_DEPTH_WORDS > 1) ? $clog2(RAM_DEPTH_WORDS) : 1;

    logic [31:0]   mem_q [RAM_DEPTH_WORDS];
    logic [AW-1:0] word_idx;
    logic          wr_en;

    // wrap the bus offset into the array
    assign word_idx = AW'(32'(req_i.ofs) % RAM_DEPTH_WORDS);

    // bus writes are ignored while reset is held
    assign wr_en = rst_n_i & req_i.sel & req_i.we;

    // contents keep whatever was there, no clear on reset
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[word_idx] <= req_i.wdata;
        end
    end

    // same-cycle read
    assign rdata_o = mem_q[word_idx];

endmodule

// ==== src/gpio_port.sv ====
/*
 * GPIO slave with an output data register and a synchronized input.
 * Output register written at GPIO_OUT_OFS drives gpio_out_o one edge
 * later. Input pins go through two flops and read at GPIO_IN_OFS.
 */

`timescale 1ns/1ps

module gpio_port #(
    parameter int unsigned GPIO_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rib_pkg::slave_req_t   req_i,
    output logic [31:0]           rdata_o,
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    output logic [GPIO_WIDTH-1:0] gpio_out_o
);

    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] sync1_q;
    logic [GPIO_WIDTH-1:0] sync2_q;
    logic                  wr_out;

    assign wr_out = req_i.sel & req_i.we & (req_i.ofs == periph_pkg::GPIO_OUT_OFS);

    // output data register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (wr_out) begin
            out_q <= req_i.wdata[GPIO_WIDTH-1:0];
        end
    end

    // two-flop synchronizer on the pins
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
        end
    end

    // zero-extended register reads
    always_comb begin
        case (req_i.ofs)
            periph_pkg::GPIO_OUT_OFS: rdata_o = 32'(out_q);
            periph_pkg::GPIO_IN_OFS:  rdata_o = 32'(sync2_q);
            default:                  rdata_o = rib_pkg::ZERO_WORD;
        endcase
    end

    assign gpio_out_o = out_q;

endmodule

// ==== src/periph_pkg.sv ====
/*
 * Peripheral register map and timer control opcodes.
 * Offsets are word offsets within a slave's 12-bit offset field.
 */

package periph_pkg;

    // timer control opcodes, written into ctrl[1:0]
    typedef enum logic [1:0] {
        // hold the count
        TMR_STOP  = 2'd0,
        // count once per cycle
        TMR_RUN   = 2'd1,
        // zero the count, drop the irq
        TMR_CLEAR = 2'd2
    } timer_op_e;

    // timer registers
    localparam logic [11:0] TMR_CTRL_OFS = 12'd0;
    localparam logic [11:0] TMR_CNT_OFS  = 12'd1;
    localparam logic [11:0] TMR_CMP_OFS  = 12'd2;

    // gpio registers
    localparam logic [11:0] GPIO_OUT_OFS = 12'd0;
    localparam logic [11:0] GPIO_IN_OFS  = 12'd1;

endpackage

// ==== src/rib_arbiter.sv ====
/*
 * Shared bus arbiter and address decoder.
 * Execute port wins over fetch by fixed priority. The owner's address
 * selects one slave by its top nibble; read data goes back to the owner
 * only. hold_o tells the fetch side its read data is not valid.
 */

`timescale 1ns/1ps

module rib_arbiter (
    input  rib_pkg::master_req_t exec_req_i,
    input  logic [31:0]          fetch_addr_i,

    input  logic [31:0]          ram_rdata_i,
    input  logic [31:0]          tmr_rdata_i,
    input  logic [31:0]          gpio_rdata_i,

    output logic [31:0]          exec_rdata_o,
    output logic [31:0]          fetch_rdata_o,

    output rib_pkg::slave_req_t  ram_req_o,
    output rib_pkg::slave_req_t  tmr_req_o,
    output rib_pkg::slave_req_t  gpio_req_o,

    output logic                 hold_o
);

    logic                 exec_owns;
    logic [31:0]          bus_addr;
    rib_pkg::slave_sel_e  bus_sel;
    rib_pkg::slave_req_t  bus_req;
    logic [31:0]          bus_rdata;

    // execute owns the bus whenever it asks
    assign exec_owns = exec_req_i.req;
    assign bus_addr  = exec_owns ? exec_req_i.addr : fetch_addr_i;

    // slave decode on the top nibble
    always_comb begin
        case (bus_addr[31:28])
            4'h0:    bus_sel = rib_pkg::SEL_RAM;
            4'h1:    bus_sel = rib_pkg::SEL_TIMER;
            4'h2:    bus_sel = rib_pkg::SEL_GPIO;
            default: bus_sel = rib_pkg::SEL_NONE;
        endcase
    end

    // common part of every slave request
    always_comb begin
        bus_req.sel   = 1'b0;
        // fetch only reads, so writes come from execute alone
        bus_req.we    = exec_owns & exec_req_i.we;
        // byte address to word offset
        bus_req.ofs   = bus_addr[13:2];
        bus_req.wdata = exec_req_i.wdata;
    end

    // per-slave copies, only the decoded one selected
    // SEL_NONE selects nobody, so its writes are dropped
    always_comb begin
        ram_req_o      = bus_req;
        tmr_req_o      = bus_req;
        gpio_req_o     = bus_req;
        ram_req_o.sel  = (bus_sel == rib_pkg::SEL_RAM);
        tmr_req_o.sel  = (bus_sel == rib_pkg::SEL_TIMER);
        gpio_req_o.sel = (bus_sel == rib_pkg::SEL_GPIO);

        // decode must never pick two slaves at once
        assert ($onehot0({ram_req_o.sel, tmr_req_o.sel, gpio_req_o.sel}))
            else $error("rib_arbiter: more than one slave selected");
    end

    // read-data return mux
    always_comb begin
        case (bus_sel)
            rib_pkg::SEL_RAM:   bus_rdata = ram_rdata_i;
            rib_pkg::SEL_TIMER: bus_rdata = tmr_rdata_i;
            rib_pkg::SEL_GPIO:  bus_rdata = gpio_rdata_i;
            default:            bus_rdata = rib_pkg::ZERO_WORD;
        endcase
    end

    // owner gets the data, the other master sees zero
    always_comb begin
        hold_o        = exec_req_i.req;
        exec_rdata_o  = exec_owns ? bus_rdata : rib_pkg::ZERO_WORD;
        fetch_rdata_o = exec_owns ? rib_pkg::ZERO_WORD : bus_rdata;

        // a held fetch must never see slave data
        assert (!hold_o || (exec_req_i.req && fetch_rdata_o == rib_pkg::ZERO_WORD))
            else $error("rib_arbiter: fetch received data while held");
    end

endmodule

// ==== src/rib_pkg.sv ====
/*
 * Bus-side types for the rib system bus.
 * Shared by the arbiter, the slaves and the top level. Referenced by
 * scoped names only.
 */

package rib_pkg;

    // request driven by one master onto the shared bus
    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } master_req_t;

    // request fanned out by the arbiter, one copy per slave
    typedef struct packed {
        logic        sel;
        logic        we;
        // word offset inside the slave window
        logic [11:0] ofs;
        logic [31:0] wdata;
    } slave_req_t;

    // decoded target, taken from address bits 31..28
    typedef enum logic [1:0] {
        SEL_RAM   = 2'd0,
        SEL_TIMER = 2'd1,
        SEL_GPIO  = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    // read data for unmapped space and for the master without the bus
    localparam logic [31:0] ZERO_WORD = 32'h0000_0000;

endpackage

// ==== src/rib_soc_top.sv ====
/*
 * Top level of the rib bus system.
 * Connects the execute and fetch master ports through the arbiter to
 * the RAM, timer and GPIO slaves. Instances and wires only.
 */

`timescale 1ns/1ps

module rib_soc_top #(
    parameter int unsigned RAM_DEPTH_WORDS = 256,
    parameter int unsigned GPIO_WIDTH      = 16
) (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // execute master
    input  rib_pkg::master_req_t  exec_req_i,
    output logic [31:0]           exec_rdata_o,

    // fetch master, read only
    input  logic [31:0]           fetch_addr_i,
    output logic [31:0]           fetch_rdata_o,
    output logic                  hold_o,

    output logic                  irq_o,
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    output logic [GPIO_WIDTH-1:0] gpio_out_o
);

    // slave requests from the arbiter
    rib_pkg::slave_req_t ram_req;
    rib_pkg::slave_req_t tmr_req;
    rib_pkg::slave_req_t gpio_req;

    // slave read words back to the arbiter
    logic [31:0] ram_rdata;
    logic [31:0] tmr_rdata;
    logic [31:0] gpio_rdata;

    rib_arbiter u_arbiter (
        .exec_req_i    (exec_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .ram_rdata_i   (ram_rdata),
        .tmr_rdata_i   (tmr_rdata),
        .gpio_rdata_i  (gpio_rdata),
        .exec_rdata_o  (exec_rdata_o),
        .fetch_rdata_o (fetch_rdata_o),
        .ram_req_o     (ram_req),
        .tmr_req_o     (tmr_req),
        .gpio_req_o    (gpio_req),
        .hold_o        (hold_o)
    );

    // slave 0x0
    data_ram #(
        .RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
    ) u_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

    // slave 0x1
    timer_unit u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (tmr_req),
        .rdata_o (tmr_rdata),
        .irq_o   (irq_o)
    );

    // slave 0x2
    gpio_port #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) u_gpio (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (gpio_req),
        .rdata_o    (gpio_rdata),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

endmodule

// ==== src/timer_unit.sv ====
/*
 * Compare timer slave with an interrupt level.
 * ctrl takes a timer_op_e opcode, cnt is the free-running count, cmp the
 * match value. irq_o is set one edge after cnt equals cmp while running
 * and stays high until TMR_CLEAR or a new compare value.
 */

`timescale 1ns/1ps

module timer_unit (
    input  logic                clk,
    input  logic                rst_n_i,
    input  rib_pkg::slave_req_t req_i,
    output logic [31:0]         rdata_o,
    output logic                irq_o
);

    periph_pkg::timer_op_e op_q;
    logic [31:0]           cnt_q;
    logic [31:0]           cmp_q;
    logic                  irq_q;
    logic                  wr_en;
    logic                  match;

    assign wr_en = req_i.sel & req_i.we;
    // match only counts while running
    assign match = (op_q == periph_pkg::TMR_RUN) && (cnt_q == cmp_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op_q  <= periph_pkg::TMR_STOP;
            cnt_q <= '0;
            cmp_q <= '0;
            irq_q <= 1'b0;
        end else begin
            // count and latch a match first
            if (op_q == periph_pkg::TMR_RUN) begin
                cnt_q <= cnt_q + 32'd1;
            end
            if (match) begin
                irq_q <= 1'b1;
            end

            // bus writes override the above
            if (wr_en && req_i.ofs == periph_pkg::TMR_CTRL_OFS) begin
                case (req_i.wdata[1:0])
                    periph_pkg::TMR_RUN: begin
                        op_q <= periph_pkg::TMR_RUN;
                    end
                    periph_pkg::TMR_CLEAR: begin
                        op_q  <= periph_pkg::TMR_CLEAR;
                        cnt_q <= '0;
                        irq_q <= 1'b0;
                    end
                    // unused code 3 behaves as stop
                    default: begin
                        op_q <= periph_pkg::TMR_STOP;
                    end
                endcase
            end
            if (wr_en && req_i.ofs == periph_pkg::TMR_CMP_OFS) begin
                // new compare value rearms the irq
                cmp_q <= req_i.wdata;
                irq_q <= 1'b0;
            end
        end
    end

    // register readback, cnt is the live count
    always_comb begin
        case (req_i.ofs)
            periph_pkg::TMR_CTRL_OFS: rdata_o = {30'd0, op_q};
            periph_pkg::TMR_CNT_OFS:  rdata_o = cnt_q;
            periph_pkg::TMR_CMP_OFS:  rdata_o = cmp_q;
            default:                  rdata_o = rib_pkg::ZERO_WORD;
        endcase
    end

    assign irq_o = irq_q;

    // irq only rises after a running compare match the cycle before
    assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(irq_o) |-> $past(op_q == periph_pkg::TMR_RUN && cnt_q == cmp_q))
        else $error("timer_unit: irq rose without a compare match");

endmodule

// ==== tests/tb_rib_soc.sv ====
/*
 * Testbench for the rib bus system.
 * Drives the execute and fetch master ports in place of a core, keeps a
 * model of RAM and GPIO, and checks reset state, RAM access on both
 * ports, priority and hold, the compare timer and the GPIO port.
 */

`timescale 1ns/1ps

module tb_rib_soc;

    localparam int unsigned RAM_WORDS = 256;
    localparam int unsigned IDX_W     = $clog2(RAM_WORDS);
    localparam int unsigned GPIO_W    = 16;
    localparam int unsigned RAM_TESTS = 8;

    // top nibble of each byte address picks the slave
    localparam logic [31:0] UNMAPPED_ADDR = 32'h5000_0000;
    localparam logic [31:0] TMR_CTRL_ADDR = 32'h1000_0000;
    localparam logic [31:0] TMR_CNT_ADDR  = 32'h1000_0004;
    localparam logic [31:0] TMR_CMP_ADDR  = 32'h1000_0008;
    localparam logic [31:0] GPIO_OUT_ADDR = 32'h2000_0000;
    localparam logic [31:0] GPIO_IN_ADDR  = 32'h2000_0004;

    logic                 clk;
    logic                 rst_n_i;
    rib_pkg::master_req_t exec_req;
    logic [31:0]          exec_rdata;
    logic [31:0]          fetch_addr;
    logic [31:0]          fetch_rdata;
    logic                 hold;
    logic                 irq;
    logic [GPIO_W-1:0]    gpio_in;
    logic [GPIO_W-1:0]    gpio_out;

    // reference model
    logic [31:0]      ram_model [RAM_WORDS];
    logic [IDX_W-1:0] written_idx [$];
    logic [GPIO_W-1:0] gpio_out_model;
    logic [GPIO_W-1:0] gpio_pins_model;

    rib_soc_top #(
        .RAM_DEPTH_WORDS (RAM_WORDS),
        .GPIO_WIDTH      (GPIO_W)
    ) rib_soc_top_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .exec_req_i    (exec_req),
        .exec_rdata_o  (exec_rdata),
        .fetch_addr_i  (fetch_addr),
        .fetch_rdata_o (fetch_rdata),
        .hold_o        (hold),
        .irq_o         (irq),
        .gpio_in_i     (gpio_in),
        .gpio_out_o    (gpio_out)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_and_stop();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual == expected)
        else begin
            $display("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    // write lands at the next rising edge
    task automatic exec_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        exec_req.req   = 1'b1;
        exec_req.we    = 1'b1;
        exec_req.addr  = addr;
        exec_req.wdata = data;
    endtask

    // combinational read sampled mid-cycle
    task automatic exec_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #2;
        exec_req.req   = 1'b1;
        exec_req.we    = 1'b0;
        exec_req.addr  = addr;
        exec_req.wdata = 32'h0;
        #5;
        data = exec_rdata;
    endtask

    // with execute idle fetch owns the bus
    task automatic fetch_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #2;
        exec_req   = '0;
        fetch_addr = addr;
        #5;
        data = fetch_rdata;
    endtask

    // hold flag is exactly the execute request
    hold_follows_exec: assert property (@(posedge clk) disable iff (!rst_n_i)
        hold == exec_req.req)
    else begin
        $display("Mismatch in hold flag: expected %0b, actual %0b", exec_req.req, hold);
        fail_and_stop();
    end

    // held fetch side gets no data
    fetch_blocked: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_req.req |-> fetch_rdata == rib_pkg::ZERO_WORD)
    else begin
        $display("Mismatch in held fetch data: expected 0x00000000, actual 0x%08h",
                 fetch_rdata);
        fail_and_stop();
    end

    initial begin
        logic [31:0]      rdata;
        logic [31:0]      wdata;
        logic [31:0]      cmp_val;
        logic [IDX_W-1:0] idx;
        logic [IDX_W-1:0] other_idx;
        int unsigned      cycles;
        logic             irq_seen;
        logic             pins_seen;

        void'($urandom(32'h0c22_d875));
        rst_n_i    = 1'b0;
        exec_req   = '0;
        fetch_addr = 32'h0;
        gpio_in    = '0;
        gpio_pins_model = '0;
        gpio_out_model  = '0;

        repeat (5) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // reset state and unmapped space
        check_word("reset hold_o", 32'd0, 32'(hold));
        check_word("reset irq_o", 32'd0, 32'(irq));
        check_word("reset gpio_out_o", 32'd0, 32'(gpio_out));
        exec_read(UNMAPPED_ADDR, rdata);
        check_word("unmapped exec read", rib_pkg::ZERO_WORD, rdata);
        fetch_read(UNMAPPED_ADDR, rdata);
        check_word("unmapped fetch read", rib_pkg::ZERO_WORD, rdata);

        // ram through both ports
        for (int i = 0; i < RAM_TESTS; i++) begin
            idx   = IDX_W'($urandom % RAM_WORDS);
            wdata = $urandom;
            ram_model[idx] = wdata;
            written_idx.push_back(idx);
            exec_write(32'(idx) << 2, wdata);
            exec_read(32'(idx) << 2, rdata);
            check_word("ram exec readback", ram_model[idx], rdata);
            fetch_read(32'(idx) << 2, rdata);
            check_word("ram fetch readback", ram_model[idx], rdata);
        end
        // later writes may have hit the same word
        foreach (written_idx[j]) begin
            fetch_read(32'(written_idx[j]) << 2, rdata);
            check_word("ram sweep", ram_model[written_idx[j]], rdata);
        end

        // fetch parked on one word while execute reads another
        idx       = written_idx[0];
        other_idx = written_idx[RAM_TESTS-1];
        fetch_read(32'(idx) << 2, rdata);
        check_word("fetch before priority", ram_model[idx], rdata);
        exec_read(32'(other_idx) << 2, rdata);
        check_word("exec data under priority", ram_model[other_idx], rdata);
        check_word("fetch data under priority", rib_pkg::ZERO_WORD, fetch_rdata);

        // timer compare and irq
        cmp_val = 32'd5 + ($urandom % 12);
        exec_write(TMR_CMP_ADDR, cmp_val);
        exec_write(TMR_CTRL_ADDR, 32'(periph_pkg::TMR_RUN));
        cycles   = 0;
        irq_seen = 1'b0;
        while (!irq_seen) begin
            exec_read(TMR_CNT_ADDR, rdata);
            assert (rdata <= cmp_val + 32'd1)
            else begin
                $display("Mismatch in timer count before irq: expected at most %0d, actual %0d",
                         cmp_val + 32'd1, rdata);
                fail_and_stop();
            end
            irq_seen = irq;
            cycles++;
            if (!irq_seen && cycles >= cmp_val + 32'd4) begin
                $display("Error: irq_o did not rise within %0d cycles of starting the timer",
                         cmp_val + 32'd4);
                fail_and_stop();
            end
        end
        exec_read(TMR_CMP_ADDR, rdata);
        check_word("timer compare readback", cmp_val, rdata);
        exec_write(TMR_CTRL_ADDR, 32'(periph_pkg::TMR_CLEAR));
        exec_read(TMR_CNT_ADDR, rdata);
        check_word("timer irq after clear", 32'd0, 32'(irq));
        check_word("timer count after clear", 32'd0, rdata);

        // gpio output register
        wdata = $urandom;
        gpio_out_model = wdata[GPIO_W-1:0];
        exec_write(GPIO_OUT_ADDR, wdata);
        exec_read(GPIO_OUT_ADDR, rdata);
        check_word("gpio_out_o pins", 32'(gpio_out_model), 32'(gpio_out));
        check_word("gpio out readback", 32'(gpio_out_model), rdata);

        // gpio inputs through the synchronizer
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            #2;
            gpio_pins_model = GPIO_W'($urandom);
            gpio_in = gpio_pins_model;
            cycles    = 0;
            pins_seen = 1'b0;
            while (!pins_seen) begin
                exec_read(GPIO_IN_ADDR, rdata);
                pins_seen = (rdata[GPIO_W-1:0] == gpio_pins_model);
                cycles++;
                if (!pins_seen && cycles >= 4) begin
                    $display("Error: gpio_in_i value did not reach the input register in 4 cycles");
                    fail_and_stop();
                end
            end
            // upper bits must read as zero
            check_word("gpio input readback", 32'(gpio_pins_model), rdata);
        end

        @(posedge clk);
        #2;
        exec_req = '0;
        @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule
